// ==== verilog/spi_eeprom_pkg.sv ====
// shared definitions for the 25xx SPI EEPROM master
//   opcode enum, command and receive structs
//   wishbone register offsets, SPI clock divider constants

package spi_eeprom_pkg;

	//////////////////////////////////////////////////
	// EEPROM opcodes
	//////////////////////////////////////////////////

	// only these four get a full sequence, other values send the opcode alone
	typedef enum logic [7:0] {
		OP_WRITE = 8'h02,	// array write, needs WREN first
		OP_READ  = 8'h03,	// array read
		OP_RDSR  = 8'h05,	// status register read
		OP_WREN  = 8'h06	// set write enable latch
	} spi_op_e;

	//////////////////////////////////////////////////
	// command and result words
	//////////////////////////////////////////////////

	typedef struct packed {
		spi_op_e     op;	// opcode byte
		logic [23:0] addr;	// 3-byte array address
		logic [1:0]  len;	// bytes minus one
		logic [31:0] wdata;	// byte 0 goes out first
	} spi_cmd_t;

	typedef struct packed {
		logic [31:0] data;	// byte 0 is first received
		logic [2:0]  count;	// bytes seen in last transfer
	} spi_rx_t;

	//////////////////////////////////////////////////
	// bus map and timing
	//////////////////////////////////////////////////

	localparam logic [2:0] REG_CMD    = 3'd0;	// opcode + len, write starts
	localparam logic [2:0] REG_ADDR   = 3'd1;
	localparam logic [2:0] REG_WDATA  = 3'd2;
	localparam logic [2:0] REG_RDATA  = 3'd3;	// read only
	localparam logic [2:0] REG_STATUS = 3'd4;	// read only, busy + count

	localparam int SCLK_HALF = 2;	// clk_i cycles per sclk half period
	localparam int DIV_W     = (SCLK_HALF > 1) ? $clog2(SCLK_HALF) : 1;

endpackage

// ==== verilog/spi_eeprom_wb_regs.sv ====
// wishbone classic slave for the SPI EEPROM master
//   register file for opcode, len, address and write word
//   start pulse on each CMD write, read mux of result and status

module spi_eeprom_wb_regs (
	input  logic                     clk_i,
	input  logic                     rstn_i,
	input  logic                     wb_cyc_i,
	input  logic                     wb_stb_i,
	input  logic                     wb_we_i,
	input  logic [2:0]               wb_adr_i,
	input  logic [31:0]              wb_dat_i,
	input  logic                     busy_i,	// from sequencer
	input  spi_eeprom_pkg::spi_rx_t  rx_i,		// from rx assembler
	output logic [31:0]              wb_dat_o,
	output logic                     wb_ack_o,
	output spi_eeprom_pkg::spi_cmd_t cmd_o,
	output logic                     start_o
);
	import spi_eeprom_pkg::*;

	logic     ack_q;
	logic     access;	// first cycle of a strobe
	logic     start_q;
	spi_cmd_t cmd_q;
	logic [31:0] dat_q;

	assign access = wb_cyc_i && wb_stb_i && !ack_q;

	//////////////////////////////////////////////////
	// ack and register writes
	//////////////////////////////////////////////////

	always_ff @(posedge clk_i, negedge rstn_i) begin
		if (!rstn_i) begin
			ack_q   <= 1'b0;
			start_q <= 1'b0;
			cmd_q   <= '0;
		end else begin
			ack_q   <= access;	// one wait cycle, single-cycle ack
			start_q <= 1'b0;
			if (access && wb_we_i) begin
				case (wb_adr_i)
					REG_CMD: begin
						cmd_q.op  <= spi_op_e'(wb_dat_i[7:0]);
						cmd_q.len <= wb_dat_i[9:8];
						start_q   <= 1'b1;	// every CMD write fires, sequencer filters
					end
					REG_ADDR:  cmd_q.addr  <= wb_dat_i[23:0];
					REG_WDATA: cmd_q.wdata <= wb_dat_i;
					default: ;	// read-only and unmapped offsets dropped
				endcase
			end
		end
	end

	//////////////////////////////////////////////////
	// read mux, captured with the ack
	//////////////////////////////////////////////////

	always_ff @(posedge clk_i) begin
		if (access && !wb_we_i) begin
			case (wb_adr_i)
				REG_CMD:    dat_q <= {22'd0, cmd_q.len, cmd_q.op};
				REG_ADDR:   dat_q <= {8'd0, cmd_q.addr};
				REG_WDATA:  dat_q <= cmd_q.wdata;
				REG_RDATA:  dat_q <= rx_i.data;
				REG_STATUS: dat_q <= {25'd0, rx_i.count, 3'd0, busy_i};
				default:    dat_q <= '0;	// unknown offset reads zero
			endcase
		end
	end

	assign wb_ack_o = ack_q;
	assign wb_dat_o = dat_q;
	assign cmd_o    = cmd_q;
	assign start_o  = start_q;

endmodule

// ==== verilog/spi_eeprom_sequencer.sv ====
// SPI mode 0 master sequencer for 25xx EEPROMs
//   clock-enable divider for sclk half periods
//   opcode, address and write-data shifters, miso sampling
//   one received byte per rx_valid pulse

module spi_eeprom_sequencer (
	input  logic                     clk_i,
	input  logic                     rstn_i,
	input  spi_eeprom_pkg::spi_cmd_t cmd_i,
	input  logic                     start_i,
	input  logic                     miso_i,
	output logic                     sclk_o,
	output logic                     mosi_o,
	output logic                     cs_n_o,
	output logic                     busy_o,
	output logic                     rx_first_o,	// accepted start
	output logic [7:0]               rx_byte_o,
	output logic                     rx_valid_o
);
	import spi_eeprom_pkg::*;

	typedef enum logic [2:0] {
		IDLE, SEL, OPCODE, ADDR, WDATA, RDATA, DESEL
	} seq_state_e;

	seq_state_e       state;
	logic [DIV_W-1:0] div_cnt;
	logic             tick;		// end of a half period
	logic [2:0]       bit_cnt;	// bit within byte, msb first
	logic [1:0]       byte_cnt;	// byte within current phase
	spi_op_e          op_q;
	logic [1:0]       len_q;
	logic [23:0]      addr_sr;	// next address byte on top
	logic [31:0]      wdata_sr;	// next write byte at bottom
	logic [7:0]       tx_sr;	// byte on the wire, mosi = msb
	logic [7:0]       rx_sr;
	logic             sclk_q;
	logic             cs_n_q;
	logic             rx_valid_q;
	logic             accept;
	logic             sample;	// rising sclk in read phase
	logic             byte_done;	// falling edge after bit 7
	logic [1:0]       data_last;	// last data byte index

	assign accept    = start_i && (state == IDLE);	// starts while busy are lost
	assign tick      = (div_cnt == DIV_W'(SCLK_HALF - 1));
	assign sample    = tick && !sclk_q && (state == RDATA);
	assign byte_done = tick && sclk_q && (bit_cnt == 3'd7);
	assign data_last = (op_q == OP_RDSR) ? 2'd0 : len_q;	// RDSR reads a single byte

	//////////////////////////////////////////////////
	// half period divider
	//////////////////////////////////////////////////

	always_ff @(posedge clk_i, negedge rstn_i) begin
		if (!rstn_i)
			div_cnt <= '0;
		else if (state == IDLE || tick)
			div_cnt <= '0;	// phase aligned to the accepted start
		else
			div_cnt <= div_cnt + 1'b1;
	end

	//////////////////////////////////////////////////
	// state machine, sclk and cs
	//////////////////////////////////////////////////

	always_ff @(posedge clk_i, negedge rstn_i) begin
		if (!rstn_i) begin
			state      <= IDLE;
			sclk_q     <= 1'b0;
			cs_n_q     <= 1'b1;
			bit_cnt    <= '0;
			byte_cnt   <= '0;
			tx_sr      <= '0;
			rx_valid_q <= 1'b0;
		end else begin
			rx_valid_q <= sample && (bit_cnt == 3'd7);	// cycle after 8th sample
			case (state)
				IDLE: if (accept) begin
					state    <= SEL;
					cs_n_q   <= 1'b0;
					tx_sr    <= cmd_i.op;	// first bit set up during SEL
					bit_cnt  <= '0;
					byte_cnt <= '0;
				end
				SEL: if (tick) begin
					sclk_q <= 1'b1;	// first rising edge
					state  <= OPCODE;
				end
				OPCODE, ADDR, WDATA, RDATA: if (tick) begin
					sclk_q <= ~sclk_q;
					if (sclk_q && !byte_done) begin
						bit_cnt <= bit_cnt + 3'd1;
						tx_sr   <= {tx_sr[6:0], 1'b0};
					end else if (byte_done) begin
						bit_cnt  <= '0;
						byte_cnt <= byte_cnt + 2'd1;
						case (state)
							OPCODE: begin
								byte_cnt <= '0;
								case (op_q)
									OP_READ, OP_WRITE: begin
										state <= ADDR;
										tx_sr <= addr_sr[23:16];
									end
									OP_RDSR: begin
										state <= RDATA;
										tx_sr <= '0;
									end
									default: begin	// opcode-only command
										state <= DESEL;
										tx_sr <= '0;
									end
								endcase
							end
							ADDR: begin
								if (byte_cnt == 2'd2) begin
									byte_cnt <= '0;
									if (op_q == OP_WRITE) begin
										state <= WDATA;
										tx_sr <= wdata_sr[7:0];
									end else begin
										state <= RDATA;
										tx_sr <= '0;	// mosi idles low while reading
									end
								end else begin
									tx_sr <= addr_sr[23:16];
								end
							end
							WDATA: begin
								if (byte_cnt == data_last) begin
									state <= DESEL;
									tx_sr <= '0;
								end else begin
									tx_sr <= wdata_sr[7:0];
								end
							end
							default: if (byte_cnt == data_last)
								state <= DESEL;	// RDATA done
						endcase
					end
				end
				DESEL: if (tick) begin
					cs_n_q <= 1'b1;	// half period after last fall
					state  <= IDLE;
				end
				default: state <= IDLE;
			endcase
		end
	end

	//////////////////////////////////////////////////
	// command capture and data shifters
	//////////////////////////////////////////////////

	always_ff @(posedge clk_i) begin
		if (accept) begin
			op_q     <= cmd_i.op;
			len_q    <= cmd_i.len;
			addr_sr  <= cmd_i.addr;
			wdata_sr <= cmd_i.wdata;
		end else if (byte_done) begin
			if (state == OPCODE || state == ADDR)
				addr_sr <= {addr_sr[15:0], 8'h00};
			if ((state == ADDR && byte_cnt == 2'd2) || state == WDATA)
				wdata_sr <= {8'h00, wdata_sr[31:8]};
		end
		if (sample)
			rx_sr <= {rx_sr[6:0], miso_i};	// msb arrives first
	end

	assign sclk_o     = sclk_q;
	assign mosi_o     = tx_sr[7];
	assign cs_n_o     = cs_n_q;
	assign busy_o     = (state != IDLE);	// falls with cs_n rising
	assign rx_first_o = accept;
	assign rx_byte_o  = rx_sr;
	assign rx_valid_o = rx_valid_q;

endmodule

// ==== verilog/spi_eeprom_rx_assembler.sv ====
// receive assembler for the SPI EEPROM master
//   packs incoming bytes into a 32-bit word, byte 0 first
//   counts bytes per transfer, cleared on each accepted start

module spi_eeprom_rx_assembler (
	input  logic                    clk_i,
	input  logic                    rstn_i,
	input  logic                    rx_first_i,	// new transfer accepted
	input  logic [7:0]              rx_byte_i,
	input  logic                    rx_valid_i,
	output spi_eeprom_pkg::spi_rx_t rx_o
);
	import spi_eeprom_pkg::*;

	spi_rx_t rx_q;

	//////////////////////////////////////////////////
	// byte lane packing
	//////////////////////////////////////////////////

	// count selects the lane, at most four bytes per transfer
	always_ff @(posedge clk_i, negedge rstn_i) begin
		if (!rstn_i) begin
			rx_q <= '0;
		end else if (rx_first_i) begin
			rx_q <= '0;	// old result dropped
		end else if (rx_valid_i) begin
			rx_q.data[8*rx_q.count[1:0] +: 8] <= rx_byte_i;
			rx_q.count                        <= rx_q.count + 3'd1;
		end
	end

	assign rx_o = rx_q;	// held until next accepted command

endmodule

// ==== verilog/spi_eeprom_top.sv ====
// top level of the SPI EEPROM master
//   wishbone register file, SPI sequencer, receive assembler

module spi_eeprom_top (
	input  logic        clk_i,
	input  logic        rstn_i,
	input  logic        wb_cyc_i,
	input  logic        wb_stb_i,
	input  logic        wb_we_i,
	input  logic [2:0]  wb_adr_i,
	input  logic [31:0] wb_dat_i,
	input  logic        miso_i,
	output logic [31:0] wb_dat_o,
	output logic        wb_ack_o,
	output logic        sclk_o,
	output logic        mosi_o,
	output logic        cs_n_o
);
	import spi_eeprom_pkg::*;

	spi_cmd_t   cmd;	// held in regs
	logic       start;
	logic       busy;
	logic       rx_first;
	logic [7:0] rx_byte;
	logic       rx_valid;
	spi_rx_t    rx;

	//////////////////////////////////////////////////
	// decode, execute, result
	//////////////////////////////////////////////////

	spi_eeprom_wb_regs spi_eeprom_wb_regs_inst (
		.clk_i    (clk_i),
		.rstn_i   (rstn_i),
		.wb_cyc_i (wb_cyc_i),
		.wb_stb_i (wb_stb_i),
		.wb_we_i  (wb_we_i),
		.wb_adr_i (wb_adr_i),
		.wb_dat_i (wb_dat_i),
		.busy_i   (busy),
		.rx_i     (rx),
		.wb_dat_o (wb_dat_o),
		.wb_ack_o (wb_ack_o),
		.cmd_o    (cmd),
		.start_o  (start)
	);

	spi_eeprom_sequencer spi_eeprom_sequencer_inst (
		.clk_i      (clk_i),
		.rstn_i     (rstn_i),
		.cmd_i      (cmd),
		.start_i    (start),
		.miso_i     (miso_i),
		.sclk_o     (sclk_o),
		.mosi_o     (mosi_o),
		.cs_n_o     (cs_n_o),
		.busy_o     (busy),
		.rx_first_o (rx_first),
		.rx_byte_o  (rx_byte),
		.rx_valid_o (rx_valid)
	);

	spi_eeprom_rx_assembler spi_eeprom_rx_assembler_inst (
		.clk_i      (clk_i),
		.rstn_i     (rstn_i),
		.rx_first_i (rx_first),
		.rx_byte_i  (rx_byte),
		.rx_valid_i (rx_valid),
		.rx_o       (rx)
	);

endmodule

// ==== dv/spi_eeprom_flash_model.sv ====
// behavioral 25xx SPI EEPROM on the SPI pins
//   256-byte array filled from a seed, write enable latch
//   READ, WRITE, WREN and RDSR in SPI mode 0

module spi_eeprom_flash_model #(
	parameter int SEED = 1
) (
	input  logic sclk_i,
	input  logic mosi_i,
	input  logic cs_n_i,
	output logic miso_o
);
	logic [7:0] mem [256];
	logic [7:0] sr;		// shift in, msb first
	logic [7:0] op;
	logic [7:0] addr;	// low address byte only
	logic       wel;	// write enable latch
	int         cnt;	// bits clocked since select

	function automatic logic [31:0] scramble(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	initial begin
		logic [31:0] h;
		wel    = 1'b0;
		op     = '0;
		cnt    = 0;
		miso_o = 1'b0;
		for (int i = 0; i < 256; i++) begin
			h      = scramble(32'(SEED + i));	// whole address feeds the hash
			mem[i] = h[7:0];
		end
	end

	always @(negedge cs_n_i) begin
		cnt = 0;
		op  = '0;	// new command
	end

	// mosi sampled on rising sclk
	always @(posedge sclk_i) begin
		if (!cs_n_i) begin
			sr  = {sr[6:0], mosi_i};
			cnt = cnt + 1;
			if (cnt == 8)
				op = sr;
			else if (cnt == 32)
				addr = sr;	// third address byte
			else if (cnt > 32 && cnt % 8 == 0 && op == 8'h02 && wel)
				mem[8'(addr + (cnt - 40) / 8)] = sr;	// wraps at 256
		end
	end

	// miso changes on falling sclk
	always @(negedge sclk_i) begin
		int         k;
		logic [7:0] st;
		st = {6'd0, wel, 1'b0};	// wip always clear
		if (!cs_n_i) begin
			if (op == 8'h03 && cnt >= 32) begin
				k      = cnt - 32;
				miso_o = mem[8'(addr + k / 8)][7 - k % 8];
			end else if (op == 8'h05 && cnt >= 8) begin
				k      = cnt - 8;
				miso_o = st[7 - k % 8];
			end
		end
	end

	always @(posedge cs_n_i) begin
		if (op == 8'h06 && cnt == 8)
			wel = 1'b1;
		else if (op == 8'h02)
			wel = 1'b0;	// write ends the latch
	end

endmodule

// ==== dv/spi_eeprom_tb.sv ====
// testbench for the SPI EEPROM master
//   clock, reset, wishbone bus tasks, xorshift stimulus
//   reference 25xx model, compare tasks, watchdog

module spi_eeprom_tb;
	import spi_eeprom_pkg::*;

	localparam int SEED     = 90002;
	localparam int NUM_RAND = 200;
	localparam int NUM_CMDS = NUM_RAND + 16;	// random plus directed
	localparam int MAX_BITS = 64;	// opcode, address, four data bytes
	localparam int WATCHDOG = NUM_CMDS * MAX_BITS * 2 * SCLK_HALF * 4 * 2;

	logic        clk_i = 1'b0;
	logic        rstn_i;
	logic        wb_cyc_i;
	logic        wb_stb_i;
	logic        wb_we_i;
	logic [2:0]  wb_adr_i;
	logic [31:0] wb_dat_i;
	logic [31:0] wb_dat_o;
	logic        wb_ack_o;
	logic        sclk;
	logic        mosi;
	logic        cs_n;
	logic        miso;

	logic [7:0]  ref_mem [256];	// reference array
	logic        ref_wel;
	logic [31:0] rng = 32'(SEED);
	int          xfer_cnt = 0;	// cs_n falling edges

	spi_eeprom_top spi_eeprom_top_inst (
		.clk_i, .rstn_i, .wb_cyc_i, .wb_stb_i, .wb_we_i, .wb_adr_i, .wb_dat_i,
		.miso_i (miso), .wb_dat_o, .wb_ack_o,
		.sclk_o (sclk), .mosi_o (mosi), .cs_n_o (cs_n)
	);

	spi_eeprom_flash_model #(.SEED(SEED)) flash_inst (
		.sclk_i (sclk), .mosi_i (mosi), .cs_n_i (cs_n), .miso_o (miso)
	);

	always #2 clk_i = ~clk_i;
	always @(negedge cs_n) xfer_cnt <= xfer_cnt + 1;

	//////////////////////////////////////////////////
	// helpers
	//////////////////////////////////////////////////

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic logic [31:0] next_rand();
		rng = xorshift(rng);
		return rng;
	endfunction

	task automatic stop_with_error(input string msg);
		$display("%s", msg);
		$display("Done: errors found");
		$fatal(1);
	endtask

	task automatic check_rx(input spi_rx_t got, input spi_rx_t exp);
		if (got !== exp)
			stop_with_error($sformatf(
				"[ERROR] rx: got data=%h count=%h, expected data=%h count=%h",
				got.data, got.count, exp.data, exp.count));
	endtask

	task automatic check_status(input logic got_busy, input logic [2:0] got_count,
			input logic exp_busy, input logic [2:0] exp_count);
		if (got_busy !== exp_busy || got_count !== exp_count)
			stop_with_error($sformatf(
				"[ERROR] status: got busy=%h count=%h, expected busy=%h count=%h",
				got_busy, got_count, exp_busy, exp_count));
	endtask

	task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp)
			stop_with_error($sformatf("[ERROR] %s: got %h, expected %h", name, got, exp));
	endtask

	//////////////////////////////////////////////////
	// wishbone bus
	//////////////////////////////////////////////////

	task automatic wb_access(input logic we, input logic [2:0] adr, input logic [31:0] dat,
			output logic [31:0] rd);
		int n;
		@(posedge clk_i);
		wb_cyc_i <= 1'b1;
		wb_stb_i <= 1'b1;
		wb_we_i  <= we;
		wb_adr_i <= adr;
		wb_dat_i <= dat;
		n = 0;
		do begin
			@(posedge clk_i);
			n++;
			if (n > 8)
				stop_with_error("no Wishbone ack within 8 cycles");
		end while (!wb_ack_o);
		rd = wb_dat_o;	// valid with ack
		wb_cyc_i <= 1'b0;
		wb_stb_i <= 1'b0;
		wb_we_i  <= 1'b0;
	endtask

	task automatic wb_write(input logic [2:0] adr, input logic [31:0] dat);
		logic [31:0] unused;
		wb_access(1'b1, adr, dat, unused);
	endtask

	task automatic wb_read(input logic [2:0] adr, output logic [31:0] rd);
		wb_access(1'b0, adr, 32'd0, rd);
	endtask

	//////////////////////////////////////////////////
	// one command against the reference model
	//////////////////////////////////////////////////

	// collide adds a WREN CMD write during the transfer
	task automatic run_cmd(input logic [7:0] op, input logic [7:0] addr, input logic [1:0] len,
			input logic [31:0] wdata, input logic collide);
		spi_rx_t     exp;
		spi_rx_t     got;
		logic [31:0] st;
		logic [31:0] rd;
		int          xfer_start;
		exp = '0;
		case (op)
			OP_READ: begin
				for (int i = 0; i <= len; i++)
					exp.data[8*i +: 8] = ref_mem[8'(addr + i)];
				exp.count = 3'(len) + 3'd1;
			end
			OP_RDSR: begin
				exp.data[7:0] = {6'd0, ref_wel, 1'b0};
				exp.count     = 3'd1;
			end
			OP_WREN: ref_wel = 1'b1;
			OP_WRITE: begin
				if (ref_wel)
					for (int i = 0; i <= len; i++)
						ref_mem[8'(addr + i)] = wdata[8*i +: 8];
				ref_wel = 1'b0;
			end
			default: ;	// opcode alone has no effect
		endcase
		xfer_start = xfer_cnt;
		wb_write(REG_ADDR, {24'd0, addr});
		wb_write(REG_WDATA, wdata);
		wb_write(REG_CMD, {22'd0, len, op});
		if (collide)
			wb_write(REG_CMD, {24'd0, OP_WREN});	// dropped while the sequencer is busy
		do
			wb_read(REG_STATUS, st);
		while (st[0]);
		wb_read(REG_RDATA, rd);
		got.data  = rd;
		got.count = st[6:4];
		check_rx(got, exp);
		check_word("cs_n transfers", 32'(xfer_cnt - xfer_start), 32'd1);
	endtask

	//////////////////////////////////////////////////
	// main sequence
	//////////////////////////////////////////////////

	initial begin
		logic [31:0] w;
		logic [31:0] rd;
		logic [31:0] r;
		logic [7:0]  addr;
		logic [1:0]  len;
		logic [31:0] wdata;
		logic [7:0]  op;
		rstn_i   <= 1'b0;
		wb_cyc_i <= 1'b0;
		wb_stb_i <= 1'b0;
		wb_we_i  <= 1'b0;
		wb_adr_i <= '0;
		wb_dat_i <= '0;
		ref_wel = 1'b0;
		for (int i = 0; i < 256; i++) begin
			w          = xorshift(32'(SEED + i));	// same fill as the flash
			ref_mem[i] = w[7:0];
		end
		repeat (3) @(posedge clk_i);
		rstn_i <= 1'b1;

		// reset values
		wb_read(REG_STATUS, rd);
		check_status(rd[0], rd[6:4], 1'b0, 3'd0);
		wb_read(REG_RDATA, rd);
		check_word("RDATA", rd, 32'd0);

		// register readback, unknown offset
		w = next_rand();
		wb_write(REG_ADDR, w);
		wb_read(REG_ADDR, rd);
		check_word("ADDR", rd, {8'd0, w[23:0]});
		w = next_rand();
		wb_write(REG_WDATA, w);
		wb_read(REG_WDATA, rd);
		check_word("WDATA", rd, w);
		wb_read(3'd5, rd);
		check_word("offset 5", rd, 32'd0);

		// write path
		r     = next_rand();
		addr  = r[7:0];
		len   = r[9:8];
		wdata = next_rand();
		run_cmd(OP_WREN, 8'd0, 2'd0, 32'd0, 1'b0);
		run_cmd(OP_WRITE, addr, len, wdata, 1'b0);
		run_cmd(OP_READ, addr, len, 32'd0, 1'b0);

		// write protection
		run_cmd(OP_WRITE, addr, len, ~wdata, 1'b0);	// latch already clear
		run_cmd(OP_READ, addr, len, 32'd0, 1'b0);
		run_cmd(OP_RDSR, 8'd0, 2'd0, 32'd0, 1'b0);
		run_cmd(OP_WREN, 8'd0, 2'd0, 32'd0, 1'b0);
		run_cmd(OP_RDSR, 8'd0, 2'd0, 32'd0, 1'b0);

		// random mix
		for (int n = 0; n < NUM_RAND; n++) begin
			r = next_rand();
			case (r % 5)
				0: op = OP_READ;
				1: op = OP_WRITE;
				2: op = OP_WREN;
				3: op = OP_RDSR;
				default: op = r[15:8];	// any opcode byte
			endcase
			run_cmd(op, r[23:16], r[25:24], next_rand(), 1'b0);
		end

		// CMD write while busy
		r = next_rand();
		run_cmd(OP_WRITE, r[7:0], r[9:8], next_rand(), 1'b0);
		run_cmd(OP_READ, r[7:0], 2'd3, 32'd0, 1'b1);
		run_cmd(OP_RDSR, 8'd0, 2'd0, 32'd0, 1'b0);

		$display("Done: no errors");
		$finish;
	end

	// watchdog
	initial begin
		#(WATCHDOG);
		$display("watchdog expired before the command sequence finished");
		$display("Done: errors found");
		$fatal(1);
	end

endmodule

// ==== sources.f ====
verilog/spi_eeprom_pkg.sv
verilog/spi_eeprom_wb_regs.sv
verilog/spi_eeprom_sequencer.sv
verilog/spi_eeprom_rx_assembler.sv
verilog/spi_eeprom_top.sv
dv/spi_eeprom_flash_model.sv
dv/spi_eeprom_tb.sv
